// File: logic/z80_bus_pkg.sv
package z80_bus_pkg;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// one address word, decoded by cycle type
	typedef union packed {
		// mreq cycle: 16K window and offset inside it
		struct packed {
			logic [1:0]  win;
			logic [13:0] offs;
		} mem;
		// iorq cycle: high byte picks the register
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} port;
	} zaddr_u;

	////////////////////////////////////////
	// extended ports, all share low byte #AF
	////////////////////////////////////////

	localparam zdata_t PORT_XT_LO   = 8'hAF;
	// #10AF..#13AF, window n at XT_PAGE_HI + n
	localparam zdata_t XT_PAGE_HI   = 8'h10;
	localparam zdata_t MEMCONF_HI   = 8'h20;

	// opfetch from #3Dxx with rom mapped enters dos
	localparam zdata_t DOS_ENTRY_HI = 8'h3D;

endpackage

// File: logic/dram_pkg.sv
package dram_pkg;

	typedef logic [7:0]  page_t;
	// page in the top 8 bits, 14-bit window offset below
	typedef logic [21:0] dram_addr_t;

	localparam int NUM_WIN = 4;

	// page map loaded at reset, window 0 first
	localparam page_t PAGE_RESET [NUM_WIN] = '{8'd0, 8'd5, 8'd2, 8'd0};

	////////////////////////////////////////
	// memconf bits
	////////////////////////////////////////

	// window 0 maps ram instead of rom
	localparam int MEMCONF_W0_RAM = 3;
	// writes allowed into rom window 0
	localparam int MEMCONF_W0_WE  = 1;

	// cpu request controller states
	localparam logic [1:0] ZM_IDLE   = 2'd0;
	localparam logic [1:0] ZM_REQ    = 2'd1;
	localparam logic [1:0] ZM_RDWAIT = 2'd2;

endpackage

// File: logic/zsignals.sv
module zsignals (
	input  logic                fclk,
	input  logic                rst_n,

	input  z80_bus_pkg::zaddr_t a,
	input  z80_bus_pkg::zdata_t din,
	input  logic                mreq_n,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic                wr_n,
	input  logic                m1_n,

	output z80_bus_pkg::zaddr_u addr,
	output z80_bus_pkg::zdata_t data,
	output logic                memrd_s,
	output logic                memwr_s,
	output logic                iowr_s,
	output logic                opfetch_s,
	output logic                rd
);
	import z80_bus_pkg::*;

	// bit 0 memrd, 1 memwr, 2 iowr, 3 opfetch
	logic [3:0] cond;
	logic [3:0] cond_q1;
	logic [3:0] cond_q2;
	logic [3:0] cond_q3;
	logic [3:0] stb;
	logic       rd_q1;
	zaddr_t     a_q1;
	zdata_t     din_q1;

	// opfetch gets its own strobe but still counts as a memory read
	assign cond[0] = !mreq_n && !rd_n;
	assign cond[1] = !mreq_n && !wr_n;
	// m1 with iorq is intack, not a port write
	assign cond[2] = !iorq_n && !wr_n && m1_n;
	assign cond[3] = !mreq_n && !rd_n && !m1_n;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			cond_q1 <= '0;
			cond_q2 <= '0;
			cond_q3 <= '0;
			stb     <= '0;
			rd_q1   <= 1'b0;
			rd      <= 1'b0;
		end else begin
			cond_q1 <= cond;
			cond_q2 <= cond_q1;
			cond_q3 <= cond_q2;
			// one pulse per rising condition
			stb     <= cond_q2 & ~cond_q3;
			rd_q1   <= !rd_n;
			rd      <= rd_q1;
		end
	end

	always_ff @(posedge fclk) begin
		a_q1   <= a;
		din_q1 <= din;
		addr   <= a_q1;
		data   <= din_q1;
	end

	assign memrd_s   = stb[0];
	assign memwr_s   = stb[1];
	assign iowr_s    = stb[2];
	assign opfetch_s = stb[3];

endmodule

// File: logic/zports.sv
module zports (
	input  logic                fclk,
	input  logic                rst_n,

	input  logic                iowr_s,
	input  z80_bus_pkg::zaddr_u addr,
	input  z80_bus_pkg::zdata_t data,

	output dram_pkg::page_t     xt_page [dram_pkg::NUM_WIN],
	output z80_bus_pkg::zdata_t memconf
);
	import z80_bus_pkg::*;
	import dram_pkg::*;

	logic               xt_hit;
	logic [NUM_WIN-1:0] page_wr;
	logic               memconf_wr;

	////////////////////////////////////////
	// port decode
	////////////////////////////////////////

	assign xt_hit = iowr_s && (addr.port.lo == PORT_XT_LO);

	always_comb begin
		for (int i = 0; i < NUM_WIN; i++) begin
			page_wr[i] = xt_hit && (addr.port.hi == XT_PAGE_HI + 8'(i));
		end
	end

	assign memconf_wr = xt_hit && (addr.port.hi == MEMCONF_HI);

	////////////////////////////////////////
	// page registers and memconf
	////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_WIN; i++) begin
				xt_page[i] <= PAGE_RESET[i];
			end
		end else begin
			for (int i = 0; i < NUM_WIN; i++) begin
				if (page_wr[i])
					xt_page[i] <= data;
			end
		end
	end

	// rom in window 0, writes blocked
	always_ff @(posedge fclk) begin
		if (!rst_n)
			memconf <= '0;
		else if (memconf_wr)
			memconf <= data;
	end

endmodule

// File: logic/pager.sv
module pager (
	input  logic                 fclk,
	input  logic                 rst_n,

	input  z80_bus_pkg::zaddr_u  addr,
	input  logic                 opfetch_s,
	input  dram_pkg::page_t      xt_page [dram_pkg::NUM_WIN],
	input  z80_bus_pkg::zdata_t  memconf,

	output dram_pkg::dram_addr_t dram_addr,
	output logic                 rw_en
);
	import z80_bus_pkg::*;
	import dram_pkg::*;

	logic  dos;
	logic  rom_w0;
	logic  dos_entry;
	page_t page;

	// window 0 holding rom
	assign rom_w0 = (addr.mem.win == 2'd0) && !memconf[MEMCONF_W0_RAM];

	// dos flag selects the rom half
	always_comb begin
		page = xt_page[addr.mem.win];
		if (rom_w0)
			page[0] = dos;
	end

	assign dram_addr = {page, addr.mem.offs};
	assign rw_en     = !(rom_w0 && !memconf[MEMCONF_W0_WE]);

	////////////////////////////////////////
	// dos flag
	////////////////////////////////////////

	assign dos_entry = rom_w0 && ({addr.mem.win, addr.mem.offs[13:8]} == DOS_ENTRY_HI);

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			dos <= 1'b0;
		end else if (opfetch_s) begin
			if (dos_entry)
				dos <= 1'b1;
			// any fetch outside window 0 leaves dos
			else if (addr.mem.win != 2'd0)
				dos <= 1'b0;
		end
	end

endmodule

// File: logic/zmem.sv
module zmem (
	input  logic                 fclk,
	input  logic                 rst_n,

	input  logic                 memrd_s,
	input  logic                 memwr_s,
	input  logic                 rd,
	input  z80_bus_pkg::zdata_t  data,
	input  dram_pkg::dram_addr_t map_addr,
	input  logic                 rw_en,

	input  logic                 dram_ready,
	input  logic                 rd_valid,
	input  z80_bus_pkg::zdata_t  dram_rdata,

	output logic                 dram_valid,
	output dram_pkg::dram_addr_t dram_addr,
	output logic                 dram_we,
	output z80_bus_pkg::zdata_t  dram_wdata,

	output z80_bus_pkg::zdata_t  d_out,
	output logic                 d_ena,
	output logic                 wait_n
);
	import dram_pkg::*;

	logic [1:0] state;
	logic       start_rd;
	logic       start_wr;

	assign start_rd = (state == ZM_IDLE) && memrd_s;
	// blocked writes are dropped, cpu never waits
	assign start_wr = (state == ZM_IDLE) && memwr_s && rw_en;

	////////////////////////////////////////
	// request FSM
	////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			state      <= ZM_IDLE;
			dram_valid <= 1'b0;
			dram_we    <= 1'b0;
			d_ena      <= 1'b0;
			wait_n     <= 1'b1;
		end else begin
			// byte stays on the bus until rd goes away
			if (!rd)
				d_ena <= 1'b0;

			case (state)
				ZM_IDLE: begin
					if (start_rd || start_wr) begin
						state      <= ZM_REQ;
						dram_valid <= 1'b1;
						dram_we    <= start_wr;
						wait_n     <= 1'b0;
					end else if (!wait_n) begin
						// access done, let the cpu go
						wait_n <= 1'b1;
						d_ena  <= !dram_we;
					end
				end
				ZM_REQ: begin
					if (dram_ready) begin
						dram_valid <= 1'b0;
						state      <= dram_we ? ZM_IDLE : ZM_RDWAIT;
					end
				end
				ZM_RDWAIT: begin
					if (rd_valid)
						state <= ZM_IDLE;
				end
				default: state <= ZM_IDLE;
			endcase
		end
	end

	// request and read payload
	always_ff @(posedge fclk) begin
		if (start_rd || start_wr)
			dram_addr <= map_addr;
		if (start_wr)
			dram_wdata <= data;
		if ((state == ZM_RDWAIT) && rd_valid)
			d_out <= dram_rdata;
	end

endmodule

// File: logic/zmem_top.sv
module zmem_top (
	input  logic                 fclk,
	input  logic                 rst_n,

	// z80
	input  z80_bus_pkg::zaddr_t  a,
	input  z80_bus_pkg::zdata_t  din,
	input  logic                 mreq_n,
	input  logic                 iorq_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  logic                 m1_n,
	output z80_bus_pkg::zdata_t  d_out,
	output logic                 d_ena,
	output logic                 wait_n,

	// dram channel
	output logic                 dram_valid,
	input  logic                 dram_ready,
	output dram_pkg::dram_addr_t dram_addr,
	output logic                 dram_we,
	output z80_bus_pkg::zdata_t  dram_wdata,
	input  logic                 rd_valid,
	input  z80_bus_pkg::zdata_t  dram_rdata
);
	import z80_bus_pkg::*;
	import dram_pkg::*;

	zaddr_u     addr;
	zdata_t     data;
	logic       memrd_s;
	logic       memwr_s;
	logic       iowr_s;
	logic       opfetch_s;
	logic       rd;
	page_t      xt_page [NUM_WIN];
	zdata_t     memconf;
	dram_addr_t map_addr;
	logic       rw_en;

	zsignals u_zsignals (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.a         (a),
		.din       (din),
		.mreq_n    (mreq_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.addr      (addr),
		.data      (data),
		.memrd_s   (memrd_s),
		.memwr_s   (memwr_s),
		.iowr_s    (iowr_s),
		.opfetch_s (opfetch_s),
		.rd        (rd)
	);

	zports u_zports (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.iowr_s  (iowr_s),
		.addr    (addr),
		.data    (data),
		.xt_page (xt_page),
		.memconf (memconf)
	);

	pager u_pager (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.addr      (addr),
		.opfetch_s (opfetch_s),
		.xt_page   (xt_page),
		.memconf   (memconf),
		.dram_addr (map_addr),
		.rw_en     (rw_en)
	);

	zmem u_zmem (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.memrd_s    (memrd_s),
		.memwr_s    (memwr_s),
		.rd         (rd),
		.data       (data),
		.map_addr   (map_addr),
		.rw_en      (rw_en),
		.dram_ready (dram_ready),
		.rd_valid   (rd_valid),
		.dram_rdata (dram_rdata),
		.dram_valid (dram_valid),
		.dram_addr  (dram_addr),
		.dram_we    (dram_we),
		.dram_wdata (dram_wdata),
		.d_out      (d_out),
		.d_ena      (d_ena),
		.wait_n     (wait_n)
	);

endmodule

// File: test/tb_clock.sv
module tb_clock (
	output logic fclk
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam time HALF_PERIOD = 4ns;

	initial fclk = 1'b0;

	always #(HALF_PERIOD) fclk = ~fclk;

endmodule

// File: test/zmem_checker.sv
module zmem_checker (
	input logic                 fclk,
	input logic                 rst_n,
	input logic                 dram_valid,
	input logic                 dram_ready,
	input dram_pkg::dram_addr_t dram_addr,
	input logic                 dram_we,
	input z80_bus_pkg::zdata_t  dram_wdata,
	input logic                 wait_n
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// payload held under back-pressure, wdata only matters for writes
	payload_stable: assert property (@(posedge fclk) disable iff (!rst_n)
		dram_valid && !dram_ready |=>
			$stable(dram_addr) && $stable(dram_we) && (!dram_we || $stable(dram_wdata)))
	else begin
		$error("DRAM request changed before its transfer");
		fail_count++;
	end

	// cpu is held for the whole request
	wait_during_req: assert property (@(posedge fclk) disable iff (!rst_n)
		dram_valid |-> !wait_n)
	else begin
		$error("wait_n high while a DRAM request is pending");
		fail_count++;
	end

	no_req_in_reset: assert property (@(posedge fclk) !rst_n |=> !dram_valid)
	else begin
		$error("dram_valid high during reset");
		fail_count++;
	end

endmodule

bind zmem zmem_checker u_zmem_checker (
	.fclk       (fclk),
	.rst_n      (rst_n),
	.dram_valid (dram_valid),
	.dram_ready (dram_ready),
	.dram_addr  (dram_addr),
	.dram_we    (dram_we),
	.dram_wdata (dram_wdata),
	.wait_n     (wait_n)
);

// File: test/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	import z80_bus_pkg::*;
	import dram_pkg::*;

	localparam int unsigned SEED = 32'hfc2b;
	localparam int TIMEOUT       = 200;
	localparam int RESET_CYCLES  = 10;
	localparam int PORT_HOLD     = 6;
	localparam int QUIET_CYCLES  = 10;
	localparam int IDLE_CYCLES   = 4;
	localparam int N_STEPS       = 17;

	typedef enum logic [1:0] {PORT_WR, MEM_WR, MEM_RD, OPFETCH} kind_t;

	typedef struct packed {
		kind_t      kind;
		zaddr_t     addr;
		zdata_t     data;
		dram_addr_t exp_addr;
		bit         exp_req;
		zdata_t     exp_rd;
	} step_t;

	// kind, cpu address, data, dram address, request, read byte
	localparam step_t STEPS [N_STEPS] = '{
		'{MEM_RD,  16'h4123, 8'h00, 22'h014123, 1'b1, 8'h79},
		'{MEM_RD,  16'h8456, 8'h00, 22'h008456, 1'b1, 8'h0C},
		'{MEM_RD,  16'hC789, 8'h00, 22'h000789, 1'b1, 8'hD3},
		'{MEM_RD,  16'h0011, 8'h00, 22'h000011, 1'b1, 8'h4B},
		'{PORT_WR, 16'h12AF, 8'h0B, 22'h000000, 1'b0, 8'h00},
		'{MEM_WR,  16'h8A5C, 8'hC3, 22'h02CA5C, 1'b1, 8'h00},
		'{MEM_WR,  16'h0100, 8'h77, 22'h000000, 1'b0, 8'h00},
		'{PORT_WR, 16'h20AF, 8'h02, 22'h000000, 1'b0, 8'h00},
		'{MEM_WR,  16'h0100, 8'h77, 22'h000100, 1'b1, 8'h00},
		'{OPFETCH, 16'h3D00, 8'h00, 22'h003D00, 1'b1, 8'h5A},
		'{MEM_RD,  16'h0042, 8'h00, 22'h004042, 1'b1, 8'h18},
		'{OPFETCH, 16'h8000, 8'h00, 22'h02C000, 1'b1, 8'h5A},
		'{MEM_RD,  16'h0042, 8'h00, 22'h000042, 1'b1, 8'h18},
		'{PORT_WR, 16'h10AF, 8'h21, 22'h000000, 1'b0, 8'h00},
		'{PORT_WR, 16'h20AF, 8'h08, 22'h000000, 1'b0, 8'h00},
		'{MEM_RD,  16'h0333, 8'h00, 22'h084333, 1'b1, 8'h69},
		'{MEM_WR,  16'h0333, 8'h9D, 22'h084333, 1'b1, 8'h00}
	};

	logic       fclk;
	logic       rst_n;
	zaddr_t     a;
	zdata_t     din;
	logic       mreq_n;
	logic       iorq_n;
	logic       rd_n;
	logic       wr_n;
	logic       m1_n;
	zdata_t     d_out;
	logic       d_ena;
	logic       wait_n;
	logic       dram_valid;
	logic       dram_ready;
	dram_addr_t dram_addr;
	logic       dram_we;
	zdata_t     dram_wdata;
	logic       rd_valid;
	zdata_t     dram_rdata;

	tb_clock u_clock (
		.fclk (fclk)
	);

	zmem_top u_dut (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.a          (a),
		.din        (din),
		.mreq_n     (mreq_n),
		.iorq_n     (iorq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.m1_n       (m1_n),
		.d_out      (d_out),
		.d_ena      (d_ena),
		.wait_n     (wait_n),
		.dram_valid (dram_valid),
		.dram_ready (dram_ready),
		.dram_addr  (dram_addr),
		.dram_we    (dram_we),
		.dram_wdata (dram_wdata),
		.rd_valid   (rd_valid),
		.dram_rdata (dram_rdata)
	);

	////////////////////////////////////////
	// error handling and compares
	////////////////////////////////////////

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_addr(input dram_addr_t got, input dram_addr_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_byte(input zdata_t got, input zdata_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_req(input bit got, input bit exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	// assertion failures in the bound checker end the run
	always @(negedge fclk) begin
		if (u_dut.u_zmem.u_zmem_checker.fail_count != 0)
			stop_on_error($sformatf("a DRAM channel assertion failed, time %0t", $time));
	end

	////////////////////////////////////////
	// bounded waits
	////////////////////////////////////////

	// sampled right at the rising edge, before the DUT flops update
	task automatic wait_transfer();
		int  n;
		bit  done;
		n    = 0;
		done = 1'b0;
		while (!done && n < TIMEOUT) begin
			@(posedge fclk);
			n++;
			done = dram_valid && dram_ready;
		end
		if (!done)
			stop_on_error($sformatf("no DRAM transfer within %0d cycles, time %0t",
				TIMEOUT, $time));
	endtask

	task automatic wait_release();
		int n;
		n = 0;
		do begin
			@(negedge fclk);
			n++;
		end while (!wait_n && n < TIMEOUT);
		if (!wait_n)
			stop_on_error($sformatf("wait_n still low after %0d cycles, time %0t",
				TIMEOUT, $time));
	endtask

	task automatic wait_read_done();
		int n;
		n = 0;
		while (d_ena && n < TIMEOUT) begin
			@(negedge fclk);
			n++;
		end
		if (d_ena)
			stop_on_error($sformatf("d_ena did not drop after rd_n rose, time %0t", $time));
	endtask

	task automatic release_bus();
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	////////////////////////////////////////
	// one bus cycle from the table
	////////////////////////////////////////

	task automatic run_step(input step_t s);
		@(negedge fclk);
		a   = s.addr;
		din = s.data;
		case (s.kind)
			PORT_WR: begin
				iorq_n = 1'b0;
				wr_n   = 1'b0;
			end
			MEM_WR: begin
				mreq_n = 1'b0;
				wr_n   = 1'b0;
			end
			MEM_RD: begin
				mreq_n = 1'b0;
				rd_n   = 1'b0;
			end
			default: begin
				mreq_n = 1'b0;
				rd_n   = 1'b0;
				m1_n   = 1'b0;
			end
		endcase

		if (s.kind == PORT_WR) begin
			repeat (PORT_HOLD) @(negedge fclk);
		end else if (!s.exp_req) begin
			// a blocked write must never stall the cpu
			for (int i = 0; i < QUIET_CYCLES; i++) begin
				@(negedge fclk);
				check_req(dram_valid, 1'b0, "dram_valid on blocked write");
				check_req(wait_n, 1'b1, "wait_n on blocked write");
			end
		end else begin
			wait_transfer();
			check_addr(dram_addr, s.exp_addr, "dram_addr");
			check_req(dram_we, s.kind == MEM_WR, "dram_we");
			if (s.kind == MEM_WR)
				check_byte(dram_wdata, s.data, "dram_wdata");
			wait_release();
			if (s.kind != MEM_WR) begin
				check_req(d_ena, 1'b1, "d_ena at wait_n release");
				check_byte(d_out, s.exp_rd, "d_out");
			end
		end

		release_bus();
		wait_read_done();
		repeat (IDLE_CYCLES) @(negedge fclk);
	endtask

	////////////////////////////////////////
	// DRAM responder
	////////////////////////////////////////

	initial begin : responder
		int unsigned gap;
		bit          is_read;
		dram_addr_t  req_addr;
		void'($urandom(SEED));
		dram_ready = 1'b0;
		rd_valid   = 1'b0;
		dram_rdata = '0;
		forever begin
			@(negedge fclk);
			if (rst_n && dram_valid) begin
				gap = $urandom % 4;
				repeat (gap) @(negedge fclk);
				dram_ready = 1'b1;
				req_addr   = dram_addr;
				is_read    = !dram_we;
				@(negedge fclk);
				dram_ready = 1'b0;
				if (is_read) begin
					// read data 1 to 3 cycles after the transfer
					gap = 1 + $urandom % 3;
					repeat (gap - 1) @(negedge fclk);
					rd_valid   = 1'b1;
					dram_rdata = req_addr[7:0] ^ 8'h5A;
					@(negedge fclk);
					rd_valid   = 1'b0;
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		a     = '0;
		din   = '0;
		release_bus();
		repeat (RESET_CYCLES) @(negedge fclk);
		rst_n = 1'b1;
		repeat (IDLE_CYCLES) @(negedge fclk);

		for (int i = 0; i < N_STEPS; i++)
			run_step(STEPS[i]);

		if (u_dut.u_zmem.u_zmem_checker.fail_count != 0) begin
			stop_on_error("DRAM channel assertions failed during the run");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// File: compile.f
logic/z80_bus_pkg.sv
logic/dram_pkg.sv
logic/zsignals.sv
logic/zports.sv
logic/pager.sv
logic/zmem.sv
logic/zmem_top.sv
test/tb_clock.sv
test/zmem_checker.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: zmem

sources:
  - logic/z80_bus_pkg.sv
  - logic/dram_pkg.sv
  - logic/zsignals.sv
  - logic/zports.sv
  - logic/pager.sv
  - logic/zmem.sv
  - logic/zmem_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/zmem_checker.sv
      - test/tb_top.sv
